//--- rtl/md5_params.svh
/*
 * MD5 core sizing
 * Word width, block size and step counts shared by the package and the RTL
 */

`ifndef MD5_PARAMS_SVH
`define MD5_PARAMS_SVH

// Width of one state or message word
`define MD5_WORD_W 32

// Message words per 512-bit block
`define MD5_BLOCK_WORDS 16

// Steps per block and per round
`define MD5_STEPS 64
`define MD5_STEPS_PER_ROUND 16

`endif

//--- rtl/md5_pkg.sv
/*
 * MD5 package
 * Word and index types plus the per-step lookups for constant,
 * rotate amount and message word index
 */

`default_nettype none

`include "md5_params.svh"

package md5_pkg;

    typedef logic [`MD5_WORD_W-1:0]                 word_t;
    typedef logic [$clog2(`MD5_STEPS)-1:0]          step_idx_t;
    typedef logic [$clog2(`MD5_BLOCK_WORDS)-1:0]    word_idx_t;
    typedef logic [1:0]                             round_t;
    typedef logic [4:0]                             shift_t;

    // floor(2^32 * abs(sin(i + 1)))
    localparam word_t K_TABLE [`MD5_STEPS] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // Rotate amounts, one row per round, cycling every four steps
    localparam shift_t SHIFT_TABLE [4][4] = '{
        '{5'd7, 5'd12, 5'd17, 5'd22},
        '{5'd5, 5'd9,  5'd14, 5'd20},
        '{5'd4, 5'd11, 5'd16, 5'd23},
        '{5'd6, 5'd10, 5'd15, 5'd21}
    };

    function automatic word_t md5_const(step_idx_t step);
        return K_TABLE[step];
    endfunction

    function automatic shift_t md5_shift(step_idx_t step);
        round_t rnd;
        rnd = round_t'(step / `MD5_STEPS_PER_ROUND);
        return SHIFT_TABLE[rnd][step[1:0]];
    endfunction

    // Message word picked by each step, taken mod 16 by truncation
    function automatic word_idx_t md5_msg_idx(step_idx_t step);
        round_t rnd;
        rnd = round_t'(step / `MD5_STEPS_PER_ROUND);
        case (rnd)
            2'd0:    return word_idx_t'(step);
            2'd1:    return word_idx_t'(5 * step + 1);
            2'd2:    return word_idx_t'(3 * step + 5);
            default: return word_idx_t'(7 * step);
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rtl/md5_step_if.sv
/*
 * MD5 step control bundle
 * Per-step schedule from the step sequencer to the round engine
 */

`default_nettype none

interface md5_step_if import md5_pkg::*; ();

    logic   load;
    logic   step_en;
    round_t round_sel;
    word_t  k_const;
    shift_t shift_amt;
    logic   last;

    modport sequencer (output load, step_en, round_sel, k_const, shift_amt, last);
    modport engine    (input  load, step_en, round_sel, k_const, shift_amt, last);

endinterface

`default_nettype wire

//--- rtl/md5_step_sequencer.sv
/*
 * MD5 step sequencer
 * Accepts a start pulse when idle, then walks steps 0 to 63, one per clock,
 * issuing the round, constant, rotate and message index of each step
 */

`default_nettype none

`include "md5_params.svh"

module md5_step_sequencer import md5_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    output logic                 busy,
    output word_idx_t            word_idx,
    md5_step_if.sequencer        step
);

    step_idx_t step_cnt;
    logic      accept;

    // A start while a block is running is dropped
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            step_cnt <= '0;
        end else if (accept) begin
            busy     <= 1'b1;
            step_cnt <= '0;
        end else if (busy) begin
            if (step_cnt == step_idx_t'(`MD5_STEPS - 1)) begin
                busy <= 1'b0;
            end
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assign step.load      = accept;
    assign step.step_en   = busy;
    assign step.round_sel = round_t'(step_cnt / `MD5_STEPS_PER_ROUND);
    assign step.k_const   = md5_const(step_cnt);
    assign step.shift_amt = md5_shift(step_cnt);
    assign step.last      = busy && (step_cnt == step_idx_t'(`MD5_STEPS - 1));
    assign word_idx       = md5_msg_idx(step_cnt);

    // Block closes right after its final step
    last_ends_block: assert property (
        @(posedge clk) disable iff (reset)
        step.last |=> !busy
    ) else $error("last step not followed by idle");

endmodule

`default_nettype wire

//--- rtl/md5_message_buffer.sv
/*
 * MD5 message buffer
 * Holds the sixteen little-endian words of a block for the whole run
 * and returns the word picked by the step schedule
 */

`default_nettype none

`include "md5_params.svh"

module md5_message_buffer import md5_pkg::*; (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     load,
    input  logic [`MD5_BLOCK_WORDS*`MD5_WORD_W-1:0]  msg,
    input  word_idx_t                                word_idx,
    output word_t                                    word
);

    word_t words [`MD5_BLOCK_WORDS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int j = 0; j < `MD5_BLOCK_WORDS; j++) begin
                words[j] <= '0;
            end
        end else if (load) begin
            // Word j sits at bits 32j upward
            for (int j = 0; j < `MD5_BLOCK_WORDS; j++) begin
                words[j] <= msg[j*`MD5_WORD_W +: `MD5_WORD_W];
            end
        end
    end

    // Zero-cycle read
    assign word = words[word_idx];

endmodule

`default_nettype wire

//--- rtl/md5_round_engine.sv
/*
 * MD5 round engine
 * One time-shared step per clock on the working state, then the
 * chaining addition of the captured input words on the last step
 */

`default_nettype none

module md5_round_engine import md5_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  word_t          a0,
    input  word_t          b0,
    input  word_t          c0,
    input  word_t          d0,
    input  word_t          word,
    md5_step_if.engine     step,
    output logic           done,
    output word_t          a_out,
    output word_t          b_out,
    output word_t          c_out,
    output word_t          d_out
);

    word_t a_q, b_q, c_q, d_q;
    word_t a_init, b_init, c_init, d_init;
    word_t f_val;
    word_t step_sum;
    word_t rotated;
    word_t b_next;

    // F, G, H and I
    always_comb begin
        case (step.round_sel)
            2'd0:    f_val = (b_q & c_q) | (~b_q & d_q);
            2'd1:    f_val = (b_q & d_q) | (c_q & ~d_q);
            2'd2:    f_val = b_q ^ c_q ^ d_q;
            default: f_val = c_q ^ (b_q | ~d_q);
        endcase
    end

    assign step_sum = a_q + f_val + step.k_const + word;
    assign rotated  = (step_sum << step.shift_amt) |
                      (step_sum >> ($bits(word_t) - step.shift_amt));
    assign b_next   = b_q + rotated;

    always_ff @(posedge clk) begin
        if (step.load) begin
            a_q    <= a0;
            b_q    <= b0;
            c_q    <= c0;
            d_q    <= d0;
            a_init <= a0;
            b_init <= b0;
            c_init <= c0;
            d_init <= d0;
        end else if (step.step_en) begin
            a_q <= d_q;
            b_q <= b_next;
            c_q <= b_q;
            d_q <= c_q;
        end
    end

    // Result registers hold until the next block finishes
    always_ff @(posedge clk) begin
        if (reset) begin
            done  <= 1'b0;
            a_out <= '0;
            b_out <= '0;
            c_out <= '0;
            d_out <= '0;
        end else begin
            done <= step.step_en && step.last;
            if (step.step_en && step.last) begin
                a_out <= a_init + d_q;
                b_out <= b_init + b_next;
                c_out <= c_init + b_q;
                d_out <= d_init + c_q;
            end
        end
    end

    done_single: assert property (
        @(posedge clk) disable iff (reset)
        done |=> !done
    ) else $error("done held for two cycles");

    no_load_mid_block: assert property (
        @(posedge clk) disable iff (reset)
        !(step.step_en && step.load)
    ) else $error("block reloaded while stepping");

endmodule

`default_nettype wire

//--- rtl/md5_core.sv
/*
 * MD5 compression core
 * Iterative 64-step MD5 over one padded block, started by a pulse,
 * reporting busy and a one-cycle done with the chained result
 */

`default_nettype none

`include "md5_params.svh"

module md5_core import md5_pkg::*; (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     start,
    input  logic [`MD5_BLOCK_WORDS*`MD5_WORD_W-1:0]  msg,
    input  word_t                                    a0,
    input  word_t                                    b0,
    input  word_t                                    c0,
    input  word_t                                    d0,
    output logic                                     busy,
    output logic                                     done,
    output word_t                                    a_out,
    output word_t                                    b_out,
    output word_t                                    c_out,
    output word_t                                    d_out
);

    md5_step_if step_bus ();

    word_idx_t word_idx;
    word_t     msg_word;

    md5_step_sequencer seq_i (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .busy     (busy),
        .word_idx (word_idx),
        .step     (step_bus.sequencer)
    );

    md5_message_buffer buf_i (
        .clk      (clk),
        .reset    (reset),
        .load     (step_bus.load),
        .msg      (msg),
        .word_idx (word_idx),
        .word     (msg_word)
    );

    md5_round_engine eng_i (
        .clk   (clk),
        .reset (reset),
        .a0    (a0),
        .b0    (b0),
        .c0    (c0),
        .d0    (d0),
        .word  (msg_word),
        .step  (step_bus.engine),
        .done  (done),
        .a_out (a_out),
        .b_out (b_out),
        .c_out (c_out),
        .d_out (d_out)
    );

endmodule

`default_nettype wire

//--- dv/md5_ref_model.svh
/*
 * Behavioral MD5 compression for the testbench
 * Plain 64-step loop over one block, chained onto the input words
 */

`ifndef MD5_REF_MODEL_SVH
`define MD5_REF_MODEL_SVH

function automatic word_t model_rotl(word_t x, shift_t amt);
    return (x << amt) | (x >> (32 - int'(amt)));
endfunction

// F, G, H and I by round number
function automatic word_t model_round_fn(int rnd, word_t b, word_t c, word_t d);
    case (rnd)
        0:       return (b & c) | (~b & d);
        1:       return (b & d) | (c & ~d);
        2:       return b ^ c ^ d;
        default: return c ^ (b | ~d);
    endcase
endfunction

function automatic void model_compress(
    input  logic [511:0] blk,
    input  word_t        ia, ib, ic, id,
    output word_t        oa, ob, oc, od
);
    word_t     a, b, c, d;
    word_t     rot_in;
    word_t     tmp;
    step_idx_t s;
    a = ia;
    b = ib;
    c = ic;
    d = id;
    for (int i = 0; i < 64; i++) begin
        s      = step_idx_t'(i);
        rot_in = a + model_round_fn(i / 16, b, c, d) + md5_const(s)
                 + blk[32 * int'(md5_msg_idx(s)) +: 32];
        tmp = d;
        d   = c;
        c   = b;
        b   = b + model_rotl(rot_in, md5_shift(s));
        a   = tmp;
    end
    oa = ia + a;
    ob = ib + b;
    oc = ic + c;
    od = id + d;
endfunction

`endif

//--- dv/md5_core_tb.sv
/*
 * MD5 core testbench
 * Known-vector and random blocks against a behavioral model, with
 * latency, start-while-busy and back-to-back checks
 */

`default_nettype none

module md5_core_tb import md5_pkg::*; ();

    localparam int DONE_TIMEOUT = 200;

    logic         clk;
    logic         reset;
    logic         start;
    logic [511:0] msg;
    word_t        a0, b0, c0, d0;
    logic         busy;
    logic         done;
    word_t        a_out, b_out, c_out, d_out;

    integer seed;
    int     errors;
    int     checks;
    bit     timed_out;

    `include "md5_ref_model.svh"

    md5_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic random_block(output logic [511:0] blk, output word_t ia, ib, ic, id);
        for (int j = 0; j < 16; j++) begin
            blk[32*j +: 32] = $random(seed);
        end
        ia = $random(seed);
        ib = $random(seed);
        ic = $random(seed);
        id = $random(seed);
    endtask

    // Waits from the start negedge until the done negedge
    task automatic wait_block(input bit poke_busy);
        int cycles;
        @(posedge clk);
        @(negedge clk);
        start = 1'b0;
        check_val("busy", 32'(busy), 32'd1);
        check_val("done", 32'(done), 32'd0);
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (poke_busy && cycles == 20) begin
                // Fresh inputs that must not reach the running block
                start = 1'b1;
                msg   = ~msg;
                a0    = ~a0;
                d0    = ~d0;
            end else begin
                start = 1'b0;
            end
            if (!done) begin
                check_val("busy", 32'(busy), 32'd1);
            end
        end
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("ERROR t=%0t done never came within %0d cycles", $time, DONE_TIMEOUT);
            return;
        end
        check_val("done latency", cycles, 32'd64);
        check_val("busy", 32'(busy), 32'd0);
    endtask

    task automatic run_block(input logic [511:0] blk, input word_t ia, ib, ic, id,
                             input bit poke_busy);
        word_t ea, eb, ec, ed;
        model_compress(blk, ia, ib, ic, id, ea, eb, ec, ed);
        msg   = blk;
        a0    = ia;
        b0    = ib;
        c0    = ic;
        d0    = id;
        start = 1'b1;
        wait_block(poke_busy);
        if (timed_out) return;
        check_val("a_out", a_out, ea);
        check_val("b_out", b_out, eb);
        check_val("c_out", c_out, ec);
        check_val("d_out", d_out, ed);
    endtask

    // Done must drop after one cycle
    task automatic close_block();
        @(negedge clk);
        check_val("done", 32'(done), 32'd0);
    endtask

    task automatic run_tests();
        logic [511:0] blk;
        word_t        ia, ib, ic, id;
        check_val("busy", 32'(busy), 32'd0);
        check_val("done", 32'(done), 32'd0);
        check_val("a_out", a_out, '0);
        check_val("b_out", b_out, '0);
        check_val("c_out", c_out, '0);
        check_val("d_out", d_out, '0);
        // Padded empty message, standard IV
        run_block(512'h80, 32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476, 1'b0);
        if (timed_out) return;
        check_val("a_out", a_out, 32'hd98c1dd4);
        check_val("b_out", b_out, 32'h04b2008f);
        check_val("c_out", c_out, 32'h980980e9);
        check_val("d_out", d_out, 32'h7e42f8ec);
        close_block();
        for (int n = 0; n < 8; n++) begin
            random_block(blk, ia, ib, ic, id);
            run_block(blk, ia, ib, ic, id, 1'b0);
            if (timed_out) return;
            close_block();
        end
        random_block(blk, ia, ib, ic, id);
        run_block(blk, ia, ib, ic, id, 1'b1);
        if (timed_out) return;
        close_block();
        // Second start lands in the done cycle of the first
        random_block(blk, ia, ib, ic, id);
        run_block(blk, ia, ib, ic, id, 1'b0);
        if (timed_out) return;
        random_block(blk, ia, ib, ic, id);
        run_block(blk, ia, ib, ic, id, 1'b0);
        if (timed_out) return;
        close_block();
    endtask

    initial begin
        seed      = 17857;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        reset     = 1'b1;
        start     = 1'b0;
        msg       = '0;
        a0        = '0;
        b0        = '0;
        c0        = '0;
        d0        = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_tests();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
+incdir+dv
rtl/md5_pkg.sv
rtl/md5_step_if.sv
rtl/md5_step_sequencer.sv
rtl/md5_message_buffer.sv
rtl/md5_round_engine.sv
rtl/md5_core.sv
dv/md5_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MD5 core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f flist.f --top-module md5_core_tb -o md5_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/md5_core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
